// ==== test/i2c_standby_testdata.txt ====
# W addr wdata slverr | R addr rdata slverr | A id data | B byte stall | E err
# All fields hex, item ids 0 start 1 start-read 2 data 3 stop 5 nack
E 0
R 10 0000000F 0
# Write transfer of 6 bytes
A 0 00
A 2 11
A 2 22
A 2 33
A 2 44
A 2 55
A 2 66
A 3 00
R 08 44332211 0
R 08 00006655 0
R 0C 00000006 0
# Read transfer of 5 bytes
W 00 00000005 0
W 04 D4C3B2A1 0
W 04 000000E5 0
A 1 00
B A1 0
B B2 0
B C3 0
B D4 0
B E5 0
A 5 00
A 3 00
R 10 0000000F 0
# Same read with ready stalls
W 00 00000005 0
W 04 D4C3B2A1 0
W 04 000000E5 0
A 1 00
B A1 1
B B2 1
B C3 1
B D4 1
B E5 1
A 5 00
A 3 00
R 10 0000000F 0
# Zero length command
W 00 00000000 0
A 1 00
R 10 0000010F 0
E 1
A 3 00
W 10 00000100 0
E 0
# NACK after 2 of 4 bytes
W 00 00000004 0
W 04 44332211 0
A 1 00
B 11 0
B 22 0
A 5 00
R 10 0000010F 0
E 1
A 3 00
W 10 00000100 0
E 0
# Write after recovery
A 0 00
A 2 DE
A 2 AD
A 2 BE
A 3 00
R 08 00BEADDE 0
R 0C 00000003 0
# APB faults
R 08 00000000 1
W 04 00000001 0
W 04 00000002 0
W 04 00000003 0
W 04 00000004 0
W 04 00000005 0
W 04 00000006 0
W 04 00000007 0
W 04 00000008 0
W 04 00000009 1
R 10 0000002D 0
E 0

// ==== files.f ====
rtl/standby_pkg.sv
rtl/tti_queue.sv
rtl/tti_apb_regs.sv
rtl/i2c_target_flow.sv
rtl/i2c_standby_top.sv
test/tb_i2c_standby.sv

// ==== test/tb_i2c_standby.sv ====
// Self-checking testbench for the standby I2C target path, replays the operations of the data file
module tb_i2c_standby;
  import standby_pkg::*;

  localparam int ApbTimeout  = 20;
  localparam int ByteTimeout = 200;

  logic        clk_i;
  logic        rst_ni;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        acq_valid;
  acq_item_t   acq_item;
  logic        tx_byte_valid;
  logic [7:0]  tx_byte;
  logic        tx_byte_ready;
  logic        err;
  logic [31:0] rng;
  int          num_ops;

  i2c_standby_top i_i2c_standby_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .apb_req_i       (apb_req),
    .apb_rsp_o       (apb_rsp),
    .acq_valid_i     (acq_valid),
    .acq_item_i      (acq_item),
    .tx_byte_valid_o (tx_byte_valid),
    .tx_byte_o       (tx_byte),
    .tx_byte_ready_i (tx_byte_ready),
    .err_o           (err)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Run aborted");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      abort_run();
    end
  endtask

  // APB setup and access phases with the response checked on the falling edge
  task automatic apb_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic exp_err);
    int cycles;
    @(posedge clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr[ApbAddrWidth-1:0];
    apb_req.pwdata  <= wdata;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!apb_rsp.pready) begin
      cycles++;
      if (cycles > ApbTimeout) begin
        $display("APB transfer to address 0x%h never saw pready", addr);
        abort_run();
      end
      @(negedge clk_i);
    end
    // Exactly one wait state per transfer
    expect_equal("pready wait states", 32'(cycles), 32'd1);
    if (!write) begin
      expect_equal("prdata", apb_rsp.prdata, exp_rdata);
    end
    expect_equal("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
    // Transfer completes on this edge
    @(posedge clk_i);
    apb_req <= '0;
  endtask

  // Random idle gap keeps items at least 4 cycles apart
  task automatic send_item(input logic [31:0] id, input logic [31:0] data);
    int gap;
    rng = xorshift32(rng);
    gap = 4 + int'(rng % 8);
    repeat (gap) @(posedge clk_i);
    acq_valid     <= 1'b1;
    acq_item.id   <= acq_id_e'(id[2:0]);
    acq_item.data <= data[7:0];
    @(posedge clk_i);
    acq_valid <= 1'b0;
  endtask

  task automatic take_byte(input logic [31:0] expected, input logic [31:0] stall);
    int cycles;
    int hold;
    cycles = 0;
    hold   = 0;
    @(negedge clk_i);
    while (!tx_byte_valid) begin
      cycles++;
      if (cycles > ByteTimeout) begin
        $display("No outgoing byte appeared within %0d cycles", ByteTimeout);
        abort_run();
      end
      @(negedge clk_i);
    end
    expect_equal("tx_byte_o", 32'(tx_byte), expected);
    if (stall != 0) begin
      rng  = xorshift32(rng);
      hold = int'(rng % 8);
    end
    // Byte must hold while ready stays low
    repeat (hold) begin
      @(negedge clk_i);
      expect_equal("tx_byte_valid_o", 32'(tx_byte_valid), 32'h1);
      expect_equal("tx_byte_o", 32'(tx_byte), expected);
    end
    @(posedge clk_i);
    tx_byte_ready <= 1'b1;
    @(posedge clk_i);
    tx_byte_ready <= 1'b0;
  endtask

  initial begin
    int              fd;
    int              n;
    logic [63:0]     op;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    logic [8*200-1:0] skip;
    rng           = 32'h3db29aae;
    num_ops       = 0;
    rst_ni        = 1'b0;
    apb_req       = '0;
    acq_valid     = 1'b0;
    acq_item      = '0;
    tx_byte_ready = 1'b0;
    fd = $fopen("test/i2c_standby_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file");
      abort_run();
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    n = $fscanf(fd, "%s", op);
    while (n == 1) begin
      if (op == "#") begin
        n = $fgets(skip, fd);
      end else begin
        num_ops++;
        case (op)
          "W", "R": n = $fscanf(fd, "%h %h %h", a, b, c);
          "A", "B": n = 1 + $fscanf(fd, "%h %h", a, b);
          "E":      n = 2 + $fscanf(fd, "%h", a);
          default: begin
            $display("Unknown operation %0d in data file", num_ops);
            abort_run();
          end
        endcase
        if (n != 3) begin
          $display("Malformed operation %0d in data file", num_ops);
          abort_run();
        end
        case (op)
          "W": apb_access(1'b1, a, b, 32'h0, c[0]);
          "R": apb_access(1'b0, a, 32'h0, b, c[0]);
          "A": send_item(a, b);
          "B": take_byte(a, b);
          default: begin
            @(negedge clk_i);
            expect_equal("err_o", 32'(err), a);
          end
        endcase
      end
      n = $fscanf(fd, "%s", op);
    end
    $fclose(fd);
    if (num_ops == 0) begin
      $display("Data file held no operations");
      abort_run();
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== rtl/i2c_standby_top.sv ====
// Top level of the standby I2C target path, joining the APB front end, queues and flow controller
module i2c_standby_top
  import standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  input  logic       acq_valid_i,
  input  acq_item_t  acq_item_i,
  output logic       tx_byte_valid_o,
  output logic [7:0] tx_byte_o,
  input  logic       tx_byte_ready_i,
  output logic       err_o
);

  // Queue ports, indexed by queue_e
  queue_wr_t q_wr     [NumQueues];
  logic      q_wready [NumQueues];
  queue_rd_t q_rd     [NumQueues];
  logic      q_rready [NumQueues];
  logic      err_pulse;

  // Host feeds CMD and TX, drains RX and RESP
  tti_apb_regs i_tti_apb_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .cmd_wr_o      (q_wr[QCmd]),
    .cmd_wready_i  (q_wready[QCmd]),
    .cmd_rvalid_i  (q_rd[QCmd].valid),
    .tx_wr_o       (q_wr[QTx]),
    .tx_wready_i   (q_wready[QTx]),
    .tx_rvalid_i   (q_rd[QTx].valid),
    .rx_rd_i       (q_rd[QRx]),
    .rx_rready_o   (q_rready[QRx]),
    .rx_wready_i   (q_wready[QRx]),
    .resp_rd_i     (q_rd[QResp]),
    .resp_rready_o (q_rready[QResp]),
    .resp_wready_i (q_wready[QResp]),
    .err_pulse_i   (err_pulse),
    .err_o         (err_o)
  );

  for (genvar q = 0; q < NumQueues; q++) begin : g_queue
    tti_queue i_tti_queue (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .wr_i     (q_wr[q]),
      .wready_o (q_wready[q]),
      .rd_o     (q_rd[q]),
      .rready_i (q_rready[q])
    );
  end

  // Flow side drains CMD and TX, feeds RX and RESP
  i2c_target_flow i_i2c_target_flow (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .acq_valid_i     (acq_valid_i),
    .acq_item_i      (acq_item_i),
    .cmd_rd_i        (q_rd[QCmd]),
    .cmd_rready_o    (q_rready[QCmd]),
    .tx_rd_i         (q_rd[QTx]),
    .tx_rready_o     (q_rready[QTx]),
    .rx_wr_o         (q_wr[QRx]),
    .rx_wready_i     (q_wready[QRx]),
    .resp_wr_o       (q_wr[QResp]),
    .resp_wready_i   (q_wready[QResp]),
    .tx_byte_valid_o (tx_byte_valid_o),
    .tx_byte_o       (tx_byte_o),
    .tx_byte_ready_i (tx_byte_ready_i),
    .err_pulse_o     (err_pulse)
  );

endmodule

// ==== rtl/i2c_target_flow.sv ====
// Flow controller between the acquired-item stream and the transfer queues of the standby target
module i2c_target_flow
  import standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       acq_valid_i,
  input  acq_item_t  acq_item_i,
  input  queue_rd_t  cmd_rd_i,
  output logic       cmd_rready_o,
  input  queue_rd_t  tx_rd_i,
  output logic       tx_rready_o,
  output queue_wr_t  rx_wr_o,
  input  logic       rx_wready_i,
  output queue_wr_t  resp_wr_o,
  input  logic       resp_wready_i,
  output logic       tx_byte_valid_o,
  output logic [7:0] tx_byte_o,
  input  logic       tx_byte_ready_i,
  output logic       err_pulse_o
);

  flow_state_e    state_q;
  flow_state_e    state_d;
  logic [31:0]    word_q;
  logic [15:0]    byte_cnt_q;
  logic [15:0]    read_len_q;
  // Stop or restart seen, response still owed
  logic           closing_q;
  logic [1:0]     byte_idx;
  tti_cmd_desc_t  cmd_desc;
  tti_resp_desc_t resp_desc;
  logic           is_start;
  logic           is_start_rd;
  logic           is_data;
  logic           is_stop;
  logic           is_end;
  logic           is_nack;
  logic           byte_sent;

  assign is_start    = acq_valid_i & (acq_item_i.id == AcqStart);
  assign is_start_rd = acq_valid_i & (acq_item_i.id == AcqStartRead);
  assign is_data     = acq_valid_i & (acq_item_i.id == AcqData);
  assign is_stop     = acq_valid_i & (acq_item_i.id == AcqStop);
  assign is_end      = is_stop | (acq_valid_i & (acq_item_i.id == AcqRestart));
  assign is_nack     = acq_valid_i & (acq_item_i.id == AcqNack);

  assign byte_idx  = byte_cnt_q[1:0];
  assign cmd_desc  = tti_cmd_desc_t'(cmd_rd_i.data);
  assign byte_sent = (state_q == SendByte) & tx_byte_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (is_start) state_d = Receive;
        else if (is_start_rd) state_d = PopCmd;
        else if (is_data || is_nack) state_d = Fault;
      end
      Receive: begin
        if (is_end) begin
          state_d = (byte_idx != 2'd0) ? PushWord : PushResp;
        end else if (is_data) begin
          if (byte_idx == 2'd3) state_d = PushWord;
        end else if (acq_valid_i) begin
          state_d = Fault;
        end
      end
      // Waiting on a full queue, a new item would be lost
      PushWord: begin
        if (rx_wready_i) state_d = closing_q ? PushResp : Receive;
        else if (acq_valid_i) state_d = Fault;
      end
      PushResp: begin
        if (resp_wready_i) state_d = Idle;
        else if (acq_valid_i) state_d = Fault;
      end
      // Any item during a read before the last byte is a NACK or out of order
      PopCmd: begin
        if (acq_valid_i) state_d = Fault;
        else if (cmd_rd_i.valid) state_d = (cmd_desc.data_length == '0) ? Fault : PopWord;
      end
      PopWord: begin
        if (acq_valid_i) state_d = Fault;
        else if (tx_rd_i.valid) state_d = SendByte;
      end
      SendByte: begin
        if (acq_valid_i) begin
          state_d = Fault;
        end else if (tx_byte_ready_i) begin
          state_d = (byte_cnt_q + 16'd1 == read_len_q) ? AwaitStop : NextByte;
        end
      end
      // Count has moved on, fetch a new word at each word boundary
      NextByte: begin
        if (acq_valid_i) state_d = Fault;
        else state_d = (byte_idx == 2'd0) ? PopWord : SendByte;
      end
      AwaitStop: begin
        if (is_end) state_d = Idle;
        else if (acq_valid_i && !is_nack) state_d = Fault;
      end
      Fault: begin
        if (is_stop) state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      byte_cnt_q <= '0;
      read_len_q <= '0;
      closing_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == Idle) begin
        byte_cnt_q <= '0;
      end else if ((state_q == Receive && is_data) || byte_sent) begin
        byte_cnt_q <= byte_cnt_q + 16'd1;
      end
      if (state_q == Idle) begin
        closing_q <= 1'b0;
      end else if (state_q == Receive && is_end) begin
        closing_q <= 1'b1;
      end
      if (state_q == PopCmd && cmd_rd_i.valid) begin
        read_len_q <= cmd_desc.data_length;
      end
    end
  end

  // Little-endian packing, a new word starts with its upper bytes cleared
  always_ff @(posedge clk_i) begin
    if (state_q == Receive && is_data) begin
      if (byte_idx == 2'd0) word_q <= {24'h0, acq_item_i.data};
      else word_q[{byte_idx, 3'b000} +: 8] <= acq_item_i.data;
    end else if (state_q == PopWord && tx_rd_i.valid) begin
      word_q <= tx_rd_i.data;
    end
  end

  assign resp_desc.reserved    = '0;
  assign resp_desc.data_length = byte_cnt_q;

  assign rx_wr_o.valid   = (state_q == PushWord);
  assign rx_wr_o.data    = word_q;
  assign resp_wr_o.valid = (state_q == PushResp);
  assign resp_wr_o.data  = resp_desc;
  assign cmd_rready_o    = (state_q == PopCmd);
  assign tx_rready_o     = (state_q == PopWord);

  // Byte holds while the bus side stalls
  assign tx_byte_valid_o = (state_q == SendByte);
  assign tx_byte_o       = word_q[{byte_idx, 3'b000} +: 8];

  assign err_pulse_o = (state_d == Fault) & (state_q != Fault);

endmodule

// ==== rtl/tti_apb_regs.sv ====
// APB register front end, feeds CMD/TX from the host, drains RX/RESP and keeps the sticky error
module tti_apb_regs
  import standby_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  output queue_wr_t cmd_wr_o,
  input  logic      cmd_wready_i,
  input  logic      cmd_rvalid_i,
  output queue_wr_t tx_wr_o,
  input  logic      tx_wready_i,
  input  logic      tx_rvalid_i,
  input  queue_rd_t rx_rd_i,
  output logic      rx_rready_o,
  input  logic      rx_wready_i,
  input  queue_rd_t resp_rd_i,
  output logic      resp_rready_o,
  input  logic      resp_wready_i,
  input  logic      err_pulse_i,
  output logic      err_o
);

  reg_addr_e            addr;
  logic                 access;
  logic                 xfer_done;
  logic                 pready_q;
  logic                 pslverr_q;
  logic [31:0]          prdata_q;
  logic [31:0]          rdata_d;
  logic                 slverr_d;
  logic [31:0]          status;
  logic [NumQueues-1:0] q_empty;
  logic [NumQueues-1:0] q_full;
  logic                 err_q;
  logic                 err_clear;

  assign addr   = reg_addr_e'(apb_req_i.paddr);
  assign access = apb_req_i.psel & apb_req_i.penable;
  // Queue side effects fire on the edge that ends the transfer
  assign xfer_done = access & pready_q & !pslverr_q;

  assign q_empty[QCmd]  = !cmd_rvalid_i;
  assign q_empty[QTx]   = !tx_rvalid_i;
  assign q_empty[QRx]   = !rx_rd_i.valid;
  assign q_empty[QResp] = !resp_rd_i.valid;
  assign q_full[QCmd]   = !cmd_wready_i;
  assign q_full[QTx]    = !tx_wready_i;
  assign q_full[QRx]    = !rx_wready_i;
  assign q_full[QResp]  = !resp_wready_i;

  always_comb begin
    status = '0;
    status[NumQueues-1:0] = q_empty;
    status[2*NumQueues-1:NumQueues] = q_full;
    status[StatusErrBit] = err_q;
  end

  // Read data and error, sampled in the first access cycle
  always_comb begin
    rdata_d  = '0;
    slverr_d = 1'b0;
    unique case (addr)
      RegCmd:  slverr_d = !apb_req_i.pwrite | !cmd_wready_i;
      RegTx:   slverr_d = !apb_req_i.pwrite | !tx_wready_i;
      RegRx: begin
        if (apb_req_i.pwrite || !rx_rd_i.valid) slverr_d = 1'b1;
        else rdata_d = rx_rd_i.data;
      end
      RegResp: begin
        if (apb_req_i.pwrite || !resp_rd_i.valid) slverr_d = 1'b1;
        else rdata_d = resp_rd_i.data;
      end
      RegStatus: begin
        if (!apb_req_i.pwrite) rdata_d = status;
      end
      default: slverr_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      // One wait state on every transfer
      pready_q  <= access & !pready_q;
      pslverr_q <= (access & !pready_q) ? slverr_d : 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !pready_q) begin
      prdata_q <= rdata_d;
    end
  end

  assign apb_rsp_o.prdata  = prdata_q;
  assign apb_rsp_o.pready  = pready_q;
  assign apb_rsp_o.pslverr = pslverr_q;

  assign cmd_wr_o.valid = xfer_done & apb_req_i.pwrite & (addr == RegCmd);
  assign cmd_wr_o.data  = apb_req_i.pwdata;
  assign tx_wr_o.valid  = xfer_done & apb_req_i.pwrite & (addr == RegTx);
  assign tx_wr_o.data   = apb_req_i.pwdata;
  assign rx_rready_o    = xfer_done & !apb_req_i.pwrite & (addr == RegRx);
  assign resp_rready_o  = xfer_done & !apb_req_i.pwrite & (addr == RegResp);

  assign err_clear = xfer_done & apb_req_i.pwrite & (addr == RegStatus) &
                     apb_req_i.pwdata[StatusErrBit];

  // A new fault wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else if (err_pulse_i) begin
      err_q <= 1'b1;
    end else if (err_clear) begin
      err_q <= 1'b0;
    end
  end

  assign err_o = err_q;

endmodule

// ==== rtl/tti_queue.sv ====
// 32-bit synchronous FIFO with valid/ready on both ports, instantiated once per transfer queue
module tti_queue
  import standby_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  queue_wr_t wr_i,
  output logic      wready_o,
  output queue_rd_t rd_o,
  input  logic      rready_i
);

  logic [31:0]              mem_q [QueueDepth];
  logic [QueuePtrWidth-1:0] wptr_q;
  logic [QueuePtrWidth-1:0] rptr_q;
  logic [QueueCntWidth-1:0] count_q;
  logic                     push;
  logic                     pop;

  assign wready_o   = (count_q != QueueCntWidth'(QueueDepth));
  assign rd_o.valid = (count_q != '0);
  // Head is shown as soon as it is stored
  assign rd_o.data  = mem_q[rptr_q];

  assign push = wr_i.valid & wready_o;
  assign pop  = rd_o.valid & rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == QueuePtrWidth'(QueueDepth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == QueuePtrWidth'(QueueDepth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wr_i.data;
    end
  end

endmodule

// ==== rtl/standby_pkg.sv ====
// Shared types and constants of the I2C standby target path, imported by every RTL module
package standby_pkg;

  // Transfer queue geometry
  localparam int QueueDepth    = 8;
  localparam int NumQueues     = 4;
  localparam int QueuePtrWidth = $clog2(QueueDepth);
  localparam int QueueCntWidth = $clog2(QueueDepth + 1);

  // APB register file
  localparam int ApbAddrWidth = 5;
  localparam int StatusErrBit = 8;

  // Item kinds delivered by the bus-level target
  typedef enum logic [2:0] {
    AcqStart     = 3'd0,
    AcqStartRead = 3'd1,
    AcqData      = 3'd2,
    AcqStop      = 3'd3,
    AcqRestart   = 3'd4,
    AcqNack      = 3'd5
  } acq_id_e;

  typedef struct packed {
    acq_id_e    id;
    logic [7:0] data;
  } acq_item_t;

  // Index of each transfer queue
  typedef enum logic [1:0] {
    QCmd  = 2'd0,
    QTx   = 2'd1,
    QRx   = 2'd2,
    QResp = 2'd3
  } queue_e;

  // Register byte addresses
  typedef enum logic [ApbAddrWidth-1:0] {
    RegCmd    = 5'h00,
    RegTx     = 5'h04,
    RegRx     = 5'h08,
    RegResp   = 5'h0C,
    RegStatus = 5'h10
  } reg_addr_e;

  typedef enum logic [3:0] {
    Idle,
    Receive,
    PushWord,
    PushResp,
    PopCmd,
    PopWord,
    SendByte,
    NextByte,
    AwaitStop,
    Fault
  } flow_state_e;

  // Read command, only the length is used
  typedef struct packed {
    logic [15:0] reserved;
    logic [15:0] data_length;
  } tti_cmd_desc_t;

  // Write response, upper half always zero
  typedef struct packed {
    logic [15:0] reserved;
    logic [15:0] data_length;
  } tti_resp_desc_t;

  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [ApbAddrWidth-1:0] paddr;
    logic [31:0]             pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } queue_wr_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } queue_rd_t;

endpackage
